// ==== hw/wb_bridge_pkg.sv ====
`default_nettype none

package wb_bridge_pkg;

  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 16;
  localparam int BYTE_W       = 8;
  localparam int SLAVE_SPAN_W = 16; // 64 KiB per slave window

  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [DATA_W-1:0] wb_data_t;
  typedef logic [BYTE_W-1:0] byte_t;

  typedef enum logic [7:0] {
    CMD_BAD   = 8'h00,
    CMD_READ  = 8'h01,
    CMD_WRITE = 8'h02
  } cmd_op_e;

  typedef enum logic [7:0] {
    RESP_READ_OK  = 8'h81,
    RESP_WRITE_OK = 8'h82,
    RESP_TIMEOUT  = 8'hE1,
    RESP_UNMAPPED = 8'hE2,
    RESP_BAD_OP   = 8'hE3
  } resp_code_e;

  typedef struct packed {
    cmd_op_e  op;
    wb_addr_t addr;
    wb_data_t data;
  } bridge_cmd_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] sel;
    wb_addr_t   adr;
    wb_data_t   dat;
  } wb_req_t;

  typedef struct packed {
    wb_data_t dat;
    logic     ack;
  } wb_rsp_t;

  typedef struct packed {
    resp_code_e code;
    wb_data_t   data;
  } bus_result_t;

  // word offsets inside the system block window
  localparam int REG_BOARD_ID = 0;
  localparam int REG_REV      = 1; // major high byte, minor low byte
  localparam int REG_REV_RCS  = 2;
  localparam int REG_SCRATCH  = 3;

  // slave k owns every address whose upper bits equal k
  function automatic logic [ADDR_W-SLAVE_SPAN_W-1:0] slave_of(wb_addr_t addr);
    return addr[ADDR_W-1:SLAVE_SPAN_W];
  endfunction

endpackage

`default_nettype wire

// ==== hw/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
  input  wire                         sys_clk_i,
  input  wire                         rst_i,
  input  wire wb_bridge_pkg::byte_t   as_data_i,
  input  wire                         as_dstrb_i,
  input  wire                         resp_done_i,
  output wb_bridge_pkg::bridge_cmd_t  cmd_o,
  output logic                        cmd_valid_o,
  output logic                        as_busy_o
);
  import wb_bridge_pkg::*;

  typedef enum logic [1:0] {IDLE, ADDR, DATA, WAIT} state_e;

  state_e     state;
  logic [1:0] byte_cnt;
  logic       is_rw;

  assign is_rw = (as_data_i == CMD_READ) || (as_data_i == CMD_WRITE);

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      state       <= IDLE;
      byte_cnt    <= '0;
      cmd_valid_o <= 1'b0;
      as_busy_o   <= 1'b0;
    end else begin
      cmd_valid_o <= 1'b0;
      case (state)
        IDLE: begin
          if (as_dstrb_i) begin
            byte_cnt <= '0;
            if (is_rw) begin
              state <= ADDR;
            end else begin
              // unknown opcode is a whole command by itself
              cmd_valid_o <= 1'b1;
              as_busy_o   <= 1'b1;
              state       <= WAIT;
            end
          end
        end
        ADDR: begin
          if (as_dstrb_i) begin
            byte_cnt <= byte_cnt + 2'd1; // wraps to 0 after 4th byte
            if (byte_cnt == 2'd3) begin
              if (cmd_o.op == CMD_WRITE) begin
                state <= DATA;
              end else begin
                cmd_valid_o <= 1'b1;
                as_busy_o   <= 1'b1;
                state       <= WAIT;
              end
            end
          end
        end
        DATA: begin
          if (as_dstrb_i) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd1) begin
              cmd_valid_o <= 1'b1;
              as_busy_o   <= 1'b1;
              state       <= WAIT;
            end
          end
        end
        WAIT: begin
          if (resp_done_i) begin // strobes ignored until here
            as_busy_o <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // msb first shift into address and data fields
  always_ff @(posedge sys_clk_i) begin
    if (as_dstrb_i) begin
      case (state)
        IDLE: begin
          cmd_o.op   <= is_rw ? cmd_op_e'(as_data_i) : CMD_BAD;
          cmd_o.data <= '0;
        end
        ADDR: cmd_o.addr <= {cmd_o.addr[ADDR_W-BYTE_W-1:0], as_data_i};
        DATA: cmd_o.data <= {cmd_o.data[DATA_W-BYTE_W-1:0], as_data_i};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/wbs_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbs_decoder #(
  parameter int NUM_SLAVES = 4,
  parameter int TIMEOUT    = 64
) (
  input  wire                                          sys_clk_i,
  input  wire                                          rst_i,
  input  wire wb_bridge_pkg::bridge_cmd_t              cmd_i,
  input  wire                                          cmd_valid_i,
  input  wire wb_bridge_pkg::wb_rsp_t [NUM_SLAVES-1:0] wb_rsp_i,
  output wb_bridge_pkg::wb_req_t                       wb_req_o,
  output logic [NUM_SLAVES-1:0]                        stb_sel_o,
  output wb_bridge_pkg::bus_result_t                   result_o,
  output logic                                         res_valid_o
);
  import wb_bridge_pkg::*;

  localparam int SEL_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
  localparam int TMR_W = $clog2(TIMEOUT + 1);

  typedef enum logic {IDLE, BUS} state_e;

  state_e           state;
  logic [SEL_W-1:0] sel_idx;
  logic [TMR_W-1:0] timer;
  logic             mapped;
  wb_rsp_t          rsp;

  assign mapped = slave_of(cmd_i.addr) < NUM_SLAVES;
  assign rsp    = wb_rsp_i[sel_idx]; // only the selected slave is listened to

  always_comb begin
    stb_sel_o          = '0;
    stb_sel_o[sel_idx] = wb_req_o.stb;
  end

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      state        <= IDLE;
      wb_req_o.cyc <= 1'b0;
      wb_req_o.stb <= 1'b0;
      res_valid_o  <= 1'b0;
      timer        <= '0;
    end else begin
      res_valid_o <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_valid_i) begin
            if (cmd_i.op == CMD_BAD) begin
              result_o    <= '{code: RESP_BAD_OP, data: '0};
              res_valid_o <= 1'b1;
            end else if (!mapped) begin
              result_o    <= '{code: RESP_UNMAPPED, data: '0}; // no bus cycle
              res_valid_o <= 1'b1;
            end else begin
              wb_req_o <= '{cyc: 1'b1, stb: 1'b1, we: (cmd_i.op == CMD_WRITE),
                            sel: 2'b11, adr: cmd_i.addr, dat: cmd_i.data};
              sel_idx  <= SEL_W'(slave_of(cmd_i.addr));
              timer    <= '0;
              state    <= BUS;
            end
          end
        end
        BUS: begin
          timer <= timer + 1'b1;
          if (rsp.ack || timer == TMR_W'(TIMEOUT - 1)) begin
            wb_req_o.cyc <= 1'b0;
            wb_req_o.stb <= 1'b0;
            res_valid_o  <= 1'b1;
            state        <= IDLE;
            if (!rsp.ack) begin
              result_o <= '{code: RESP_TIMEOUT, data: '0}; // slot never answered
            end else if (wb_req_o.we) begin
              result_o <= '{code: RESP_WRITE_OK, data: '0};
            end else begin
              result_o <= '{code: RESP_READ_OK, data: rsp.dat};
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_stb_in_cyc: assert property (@(posedge sys_clk_i) disable iff (rst_i)
    wb_req_o.stb |-> wb_req_o.cyc);

  a_one_slave: assert property (@(posedge sys_clk_i) disable iff (rst_i)
    $onehot0(stb_sel_o));

endmodule

`default_nettype wire

// ==== hw/sys_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_block #(
  parameter wb_bridge_pkg::wb_data_t BOARD_ID  = 16'h0000,
  parameter wb_bridge_pkg::byte_t    REV_MAJOR = 8'h00,
  parameter wb_bridge_pkg::byte_t    REV_MINOR = 8'h00,
  parameter wb_bridge_pkg::wb_data_t REV_RCS   = 16'h0000
) (
  input  wire                          sys_clk_i,
  input  wire                          rst_i,
  input  wire wb_bridge_pkg::wb_req_t  wb_req_i,
  input  wire                          stb_i,
  output wb_bridge_pkg::wb_rsp_t       wb_rsp_o
);
  import wb_bridge_pkg::*;

  logic [SLAVE_SPAN_W-2:0] word;
  logic                    access;
  logic                    ack_q;
  wb_data_t                scratch;
  wb_data_t                rd_mux;
  wb_data_t                rd_q;

  assign word   = wb_req_i.adr[SLAVE_SPAN_W-1:1]; // byte address, 16-bit words
  assign access = wb_req_i.cyc && stb_i && !ack_q; // once per strobe

  always_comb begin
    case (word)
      REG_BOARD_ID: rd_mux = BOARD_ID;
      REG_REV:      rd_mux = {REV_MAJOR, REV_MINOR};
      REG_REV_RCS:  rd_mux = REV_RCS;
      REG_SCRATCH:  rd_mux = scratch;
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      ack_q   <= 1'b0;
      scratch <= '0;
    end else begin
      ack_q <= access;
      if (access && wb_req_i.we && word == REG_SCRATCH) begin
        if (wb_req_i.sel[1]) begin
          scratch[DATA_W-1:BYTE_W] <= wb_req_i.dat[DATA_W-1:BYTE_W];
        end
        if (wb_req_i.sel[0]) begin
          scratch[BYTE_W-1:0] <= wb_req_i.dat[BYTE_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (access) begin
      rd_q <= rd_mux;
    end
  end

  assign wb_rsp_o = '{dat: rd_q, ack: ack_q};

endmodule

`default_nettype wire

// ==== hw/resp_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_encoder (
  input  wire                              sys_clk_i,
  input  wire                              rst_i,
  input  wire wb_bridge_pkg::bus_result_t  result_i,
  input  wire                              res_valid_i,
  input  wire                              as_busy_i,
  output wb_bridge_pkg::byte_t             as_data_o,
  output logic                             as_dstrb_o,
  output logic                             resp_done_o
);
  import wb_bridge_pkg::*;

  typedef enum logic {IDLE, SEND} state_e;

  state_e      state;
  bus_result_t res_q;
  logic [1:0]  idx;
  logic [1:0]  last_idx;

  // only a good read carries data bytes
  assign last_idx = (res_q.code == RESP_READ_OK) ? 2'd2 : 2'd0;

  // sink busy holds the current byte
  assign as_dstrb_o = (state == SEND) && !as_busy_i;

  always_comb begin
    case (idx)
      2'd1:    as_data_o = res_q.data[DATA_W-1:BYTE_W];
      2'd2:    as_data_o = res_q.data[BYTE_W-1:0];
      default: as_data_o = res_q.code;
    endcase
  end

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      state       <= IDLE;
      idx         <= '0;
      resp_done_o <= 1'b0;
    end else begin
      resp_done_o <= 1'b0;
      case (state)
        IDLE: begin
          if (res_valid_i) begin
            idx   <= '0;
            state <= SEND;
          end
        end
        SEND: begin
          if (as_dstrb_o) begin
            if (idx == last_idx) begin
              resp_done_o <= 1'b1;
              state       <= IDLE;
            end else begin
              idx <= idx + 2'd1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (res_valid_i) begin
      res_q <= result_i;
    end
  end

  a_no_strobe_busy: assert property (@(posedge sys_clk_i) disable iff (rst_i)
    as_busy_i |-> !as_dstrb_o);

  // upstream keeps a single command in flight
  a_one_in_flight: assert property (@(posedge sys_clk_i) disable iff (rst_i)
    res_valid_i |-> state == IDLE);

endmodule

`default_nettype wire

// ==== hw/wb_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_bridge_top #(
  parameter int                      NUM_SLAVES = 4,
  parameter int                      TIMEOUT    = 64,
  parameter wb_bridge_pkg::wb_data_t BOARD_ID   = 16'h0b0a,
  parameter wb_bridge_pkg::byte_t    REV_MAJOR  = 8'h02,
  parameter wb_bridge_pkg::byte_t    REV_MINOR  = 8'h05,
  parameter wb_bridge_pkg::wb_data_t REV_RCS    = 16'h3c1e
) (
  input  wire                        sys_clk_i,
  input  wire                        rst_i,
  input  wire wb_bridge_pkg::byte_t  as_data_i,
  input  wire                        as_dstrb_i,
  input  wire                        as_busy_i,
  output wb_bridge_pkg::byte_t       as_data_o,
  output logic                       as_dstrb_o,
  output logic                       as_busy_o
);
  import wb_bridge_pkg::*;

  wire bridge_cmd_t                cmd;
  wire                             cmd_valid;
  wire bus_result_t                result;
  wire                             res_valid;
  wire                             resp_done;
  wire wb_req_t                    wb_req;
  wire [NUM_SLAVES-1:0]            stb_sel;
  wire wb_rsp_t [NUM_SLAVES-1:0]   wb_rsp;

  cmd_decoder cmd_decoder_inst (
    .sys_clk_i(sys_clk_i), .rst_i(rst_i),
    .as_data_i(as_data_i), .as_dstrb_i(as_dstrb_i),
    .resp_done_i(resp_done),
    .cmd_o(cmd), .cmd_valid_o(cmd_valid), .as_busy_o(as_busy_o)
  );

  wbs_decoder #(
    .NUM_SLAVES(NUM_SLAVES),
    .TIMEOUT(TIMEOUT)
  ) wbs_decoder_inst (
    .sys_clk_i(sys_clk_i), .rst_i(rst_i),
    .cmd_i(cmd), .cmd_valid_i(cmd_valid), .wb_rsp_i(wb_rsp),
    .wb_req_o(wb_req), .stb_sel_o(stb_sel),
    .result_o(result), .res_valid_o(res_valid)
  );

  sys_block #(
    .BOARD_ID(BOARD_ID),
    .REV_MAJOR(REV_MAJOR),
    .REV_MINOR(REV_MINOR),
    .REV_RCS(REV_RCS)
  ) sys_block_inst ( // slot 0
    .sys_clk_i(sys_clk_i), .rst_i(rst_i),
    .wb_req_i(wb_req), .stb_i(stb_sel[0]),
    .wb_rsp_o(wb_rsp[0])
  );

  // empty slots never ack, so accesses there time out
  for (genvar k = 1; k < NUM_SLAVES; k++) begin : g_empty_slot
    assign wb_rsp[k] = '0;
  end

  resp_encoder resp_encoder_inst (
    .sys_clk_i(sys_clk_i), .rst_i(rst_i),
    .result_i(result), .res_valid_i(res_valid), .as_busy_i(as_busy_i),
    .as_data_o(as_data_o), .as_dstrb_o(as_dstrb_o), .resp_done_o(resp_done)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_checks.svh ====
task automatic check_code(input string name, input resp_code_e exp_code,
                          input resp_code_e act_code);
  if (act_code !== exp_code) begin
    $display("CHECK FAILED %s: code expected %h, actual %h", name, exp_code, act_code);
    err_count++; // counter of the including module
  end
endtask

task automatic check_data(input string name, input wb_data_t exp_data,
                          input wb_data_t act_data);
  if (act_data !== exp_data) begin
    $display("CHECK FAILED %s: data expected %h, actual %h", name, exp_data, act_data);
    err_count++;
  end
endtask

// never returns 0 from a nonzero state
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// ==== testbench/tb_wb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_bridge;
  import wb_bridge_pkg::*;

  localparam int    WAIT_LIMIT = 2000;
  localparam string STIM_FILE  = "testbench/bridge_stim.txt";

  logic        clk;
  logic        rst;
  byte_t       in_data;
  logic        in_strobe;
  logic        out_busy;
  byte_t       out_data;
  logic        out_strobe;
  logic        cmd_busy;

  int          err_count;
  int          test_count;
  int          fail_count;
  logic        timed_out;
  logic [31:0] rng;
  byte_t       resp_q[$];

  `include "tb_checks.svh"

  wb_bridge_top UUT (
    .sys_clk_i(clk), .rst_i(rst),
    .as_data_i(in_data), .as_dstrb_i(in_strobe), .as_busy_i(out_busy),
    .as_data_o(out_data), .as_dstrb_o(out_strobe), .as_busy_o(cmd_busy)
  );

  always #5 clk = ~clk;

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (cmd_busy && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (cmd_busy) begin
      $display("timeout: bridge still busy before the next command");
      timed_out = 1'b1;
    end
  endtask

  task automatic send_byte(input byte_t b);
    @(negedge clk);
    in_data   = b;
    in_strobe = 1'b1;
  endtask

  task automatic send_command(input byte_t op, input wb_addr_t addr, input wb_data_t data);
    send_byte(op);
    if (op == CMD_READ || op == CMD_WRITE) begin
      for (int i = 3; i >= 0; i--) begin
        send_byte(addr[8*i +: 8]); // msb first
      end
    end
    if (op == CMD_WRITE) begin
      send_byte(data[15:8]);
      send_byte(data[7:0]);
    end
    @(negedge clk);
    in_strobe = 1'b0;
  endtask

  // runs until as_busy_o falls, random stalls on the response side
  task automatic collect_response();
    int cycles;
    cycles = 0;
    resp_q.delete();
    while (cmd_busy && cycles < WAIT_LIMIT) begin
      rng       = xorshift32(rng);
      out_busy  = (rng[3:0] < 4'd6);
      in_data   = rng[23:16];
      in_strobe = rng[8]; // junk byte, bridge is busy
      #1;
      if (out_strobe) begin
        resp_q.push_back(out_data);
      end
      @(negedge clk);
      cycles++;
    end
    in_strobe = 1'b0;
    out_busy  = 1'b0;
    if (cmd_busy) begin
      $display("timeout: response did not finish within %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_test(input string name, input byte_t op, input wb_addr_t addr,
                          input wb_data_t data, input resp_code_e exp_code,
                          input wb_data_t exp_data);
    int errs_before;
    int exp_len;
    errs_before = err_count;
    exp_len     = (exp_code == RESP_READ_OK) ? 3 : 1; // code plus two data bytes
    wait_idle();
    if (timed_out) return;
    send_command(op, addr, data);
    collect_response();
    if (timed_out) return;
    if (resp_q.size() != exp_len) begin
      $display("%s: got %0d response bytes where %0d were expected",
               name, resp_q.size(), exp_len);
      err_count++;
    end else begin
      check_code(name, exp_code, resp_code_e'(resp_q[0]));
      if (exp_len == 3) begin
        check_data(name, exp_data, {resp_q[1], resp_q[2]});
      end
    end
    test_count++;
    if (err_count != errs_before) begin
      fail_count++;
      $display("test %s failed", name);
    end else begin
      $display("test %s passed", name);
    end
  endtask

  initial begin
    int               fd;
    int               n;
    string            line;
    logic [8*24-1:0]  name_bits;
    logic [31:0]      f_op;
    logic [31:0]      f_addr;
    logic [31:0]      f_data;
    logic [31:0]      f_code;
    logic [31:0]      f_exp;
    clk        = 1'b0;
    rst        = 1'b1;
    in_data    = '0;
    in_strobe  = 1'b0;
    out_busy   = 1'b0;
    err_count  = 0;
    test_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;
    rng        = 32'd80465;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open stimulus file %s", STIM_FILE);
      err_count++;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    while (fd != 0 && !timed_out && !$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%s %h %h %h %h %h", name_bits, f_op, f_addr, f_data,
                    f_code, f_exp) == 6) begin
          run_test(string'(name_bits), byte_t'(f_op), f_addr, wb_data_t'(f_data),
                   resp_code_e'(f_code[7:0]), wb_data_t'(f_exp));
        end else begin
          $display("stimulus line could not be parsed: %s", line);
          err_count++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("tests run %0d, tests failed %0d, check errors %0d",
             test_count, fail_count, err_count);
    if (timed_out || err_count != 0 || test_count == 0) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/bridge_stim.txt ====
# name opcode address data expected_code expected_data (all hex)
# data is ignored for reads, expected_data only counts for code 81
rd_board_id     01 00000000 0000 81 0b0a
rd_rev          01 00000002 0000 81 0205
rd_rcs          01 00000004 0000 81 3c1e
rd_scratch_rst  01 00000006 0000 81 0000
wr_scratch      02 00000006 a55a 82 0000
rd_scratch      01 00000006 0000 81 a55a
wr_scratch_2    02 00000006 1234 82 0000
rd_scratch_2    01 00000006 0000 81 1234
rd_unused_word  01 00000010 0000 81 0000
wr_board_id     02 00000000 ffff 82 0000
rd_board_id_2   01 00000000 0000 81 0b0a
rd_slot1        01 00010000 0000 e1 0000
wr_slot2        02 00020004 beef e1 0000
rd_slot3        01 0003fffe 0000 e1 0000
rd_unmapped     01 00040000 0000 e2 0000
wr_unmapped     02 ffff0006 5555 e2 0000
bad_op          7f 00000000 0000 e3 0000
bad_op_zero     00 00000000 0000 e3 0000
rd_scratch_end  01 00000006 0000 81 1234

// ==== vlog.f ====
+incdir+testbench
hw/wb_bridge_pkg.sv
hw/cmd_decoder.sv
hw/wbs_decoder.sv
hw/sys_block.sv
hw/resp_encoder.sv
hw/wb_bridge_top.sv
testbench/tb_wb_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wb_bridge -f vlog.f -o sim_tb_wb_bridge
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_wb_bridge)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
